/* hdl/decodeStage.sv */
module decodeStage import rvPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  word_t       ifPc,
  input  word_t       ifInstr,
  output regAddr_t    rfAddrA,
  output regAddr_t    rfAddrB,
  input  word_t       rfDataA,
  input  word_t       rfDataB,
  output word_t       exPc,
  output word_t       exImm,
  output word_t       exRs1Val,
  output word_t       exRs2Val,
  output regAddr_t    exRs1,
  output regAddr_t    exRs2,
  output regAddr_t    exRd,
  output aluOp_t      exAluOp,
  output branchKind_t exBranch,
  output logic        exUsePc,
  output logic        exUseImm,
  output logic        exRegWrite
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  regAddr_t    rd;

  logic        legal;
  logic        writesRd;
  aluOp_t      aluOp;
  branchKind_t branch;
  logic        usePc;
  logic        useImm;
  logic        regWrite;
  word_t       imm;

  assign opcode = ifInstr[6:0];
  assign funct3 = ifInstr[14:12];
  assign funct7 = ifInstr[31:25];
  assign rd     = ifInstr[11:7];

  // LUI reads x0 so the ALU computes 0 + imm
  assign rfAddrA = (opcode == opLui) ? '0 : ifInstr[19:15];
  assign rfAddrB = ifInstr[24:20];

  // ====================
  // Instruction decoder
  // ====================
  always_comb begin
    legal    = 1'b0;
    writesRd = 1'b0;
    aluOp    = aluNone;
    branch   = brNone;
    usePc    = 1'b0;
    useImm   = 1'b0;
    imm      = '0;
    case (opcode)
      opImm: begin
        writesRd = 1'b1;
        useImm   = 1'b1;
        imm      = {{20{ifInstr[31]}}, ifInstr[31:20]};
        legal    = 1'b1;
        case (funct3)
          3'b000:  aluOp = aluAdd;
          3'b010:  aluOp = aluSlt;
          3'b011:  aluOp = aluSltu;
          3'b001:  aluOp = aluSll;
          3'b101:  aluOp = aluSrl;
          default: legal = 1'b0;
        endcase
        // Shift immediates need a clean funct7
        if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != f7Base) legal = 1'b0;
      end
      opReg: begin
        writesRd = 1'b1;
        if (funct7 == f7Base && funct3 == 3'b000) begin
          aluOp = aluAdd;
          legal = 1'b1;
        end else if (funct7 == f7Base && funct3 == 3'b010) begin
          aluOp = aluSlt;
          legal = 1'b1;
        end else if (funct7 == f7Base && funct3 == 3'b011) begin
          aluOp = aluSltu;
          legal = 1'b1;
        end else if (funct7 == f7Alt && funct3 == 3'b000) begin
          aluOp = aluSub;
          legal = 1'b1;
        end else if (funct7 == f7Mul && funct3 == 3'b000) begin
          aluOp = aluMul;
          legal = 1'b1;
        end
      end
      opLui, opAuipc: begin
        writesRd = 1'b1;
        aluOp    = aluAdd;
        usePc    = (opcode == opAuipc);
        useImm   = 1'b1;
        imm      = {ifInstr[31:12], 12'b0};
        legal    = 1'b1;
      end
      opBranch: begin
        imm   = {{20{ifInstr[31]}}, ifInstr[7], ifInstr[30:25], ifInstr[11:8], 1'b0};
        legal = 1'b1;
        case (funct3)
          3'b000:  branch = brBeq;
          3'b001:  branch = brBne;
          3'b100:  branch = brBlt;
          3'b101:  branch = brBge;
          default: legal  = 1'b0;
        endcase
      end
      opJal: begin
        writesRd = 1'b1;
        branch   = brJal;
        imm      = {{12{ifInstr[31]}}, ifInstr[19:12], ifInstr[20], ifInstr[30:21], 1'b0};
        legal    = 1'b1;
      end
      opJalr: begin
        writesRd = 1'b1;
        branch   = brJalr;
        aluOp    = aluAdd;   // rs1 + imm gives the target
        useImm   = 1'b1;
        imm      = {{20{ifInstr[31]}}, ifInstr[31:20]};
        legal    = (funct3 == 3'b000);
      end
      default: ;
    endcase
  end

  assign regWrite = legal && writesRd && (rd != '0);

  // ====================
  // Decode/execute register
  // ====================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      exAluOp    <= aluNone;
      exBranch   <= brNone;
      exUsePc    <= 1'b0;
      exUseImm   <= 1'b0;
      exRegWrite <= 1'b0;
      exRd       <= '0;
    end else if (flush) begin
      exAluOp    <= aluNone;
      exBranch   <= brNone;
      exUsePc    <= 1'b0;
      exUseImm   <= 1'b0;
      exRegWrite <= 1'b0;
      exRd       <= '0;
    end else begin
      exAluOp    <= aluOp;
      exBranch   <= legal ? branch : brNone;  // Unknown encodings become bubbles
      exUsePc    <= usePc;
      exUseImm   <= useImm;
      exRegWrite <= regWrite;
      exRd       <= rd;
    end
  end

  always_ff @(posedge clock) begin
    exPc     <= ifPc;
    exImm    <= imm;
    exRs1Val <= rfDataA;
    exRs2Val <= rfDataB;
    exRs1    <= rfAddrA;
    exRs2    <= rfAddrB;
  end

endmodule

/* hdl/executeStage.sv */
module executeStage import rvPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        flush,
  input  word_t       exPc,
  input  word_t       exImm,
  input  word_t       exRs1Val,
  input  word_t       exRs2Val,
  input  regAddr_t    exRs1,
  input  regAddr_t    exRs2,
  input  regAddr_t    exRd,
  input  aluOp_t      exAluOp,
  input  branchKind_t exBranch,
  input  logic        exUsePc,
  input  logic        exUseImm,
  input  logic        exRegWrite,
  input  logic        fwdValid,
  input  regAddr_t    fwdRd,
  input  word_t       fwdValue,
  input  logic        wbEnable,
  input  regAddr_t    wbReg,
  input  word_t       wbData,
  output word_t       mePc,
  output word_t       meAluResult,
  output word_t       meImm,
  output regAddr_t    meRd,
  output branchKind_t meBranch,
  output logic        meRegWrite,
  output logic        meZero,
  output logic        meLess
);

  word_t srcA;
  word_t srcB;
  word_t opA;
  word_t opB;
  word_t aluResult;

  // ====================
  // Forwarding
  // ====================
  // Resolve stage is younger than writeback, so it takes priority
  always_comb begin
    if (fwdValid && exRs1 != '0 && fwdRd == exRs1) begin
      srcA = fwdValue;
    end else if (wbEnable && exRs1 != '0 && wbReg == exRs1) begin
      srcA = wbData;
    end else begin
      srcA = exRs1Val;
    end
    if (fwdValid && exRs2 != '0 && fwdRd == exRs2) begin
      srcB = fwdValue;
    end else if (wbEnable && exRs2 != '0 && wbReg == exRs2) begin
      srcB = wbData;
    end else begin
      srcB = exRs2Val;
    end
  end

  assign opA = exUsePc  ? exPc  : srcA;   // AUIPC
  assign opB = exUseImm ? exImm : srcB;

  // ====================
  // ALU
  // ====================
  always_comb begin
    case (exAluOp)
      aluAdd:  aluResult = opA + opB;
      aluSub:  aluResult = opA - opB;
      aluSrl:  aluResult = opA >> opB[4:0];
      aluSll:  aluResult = opA << opB[4:0];
      aluSlt:  aluResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
      aluSltu: aluResult = {{(xlen-1){1'b0}}, opA < opB};
      aluMul:  aluResult = opA * opB;    // Low half only
      default: aluResult = '0;
    endcase
  end

  // Execute/resolve register
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      meBranch   <= brNone;
      meRegWrite <= 1'b0;
      meRd       <= '0;
    end else if (flush) begin
      meBranch   <= brNone;
      meRegWrite <= 1'b0;
      meRd       <= '0;
    end else begin
      meBranch   <= exBranch;
      meRegWrite <= exRegWrite;
      meRd       <= exRd;
    end
  end

  always_ff @(posedge clock) begin
    mePc        <= exPc;
    meAluResult <= aluResult;
    meImm       <= exImm;
    meZero      <= (srcA == srcB);
    meLess      <= ($signed(srcA) < $signed(srcB));  // True signed compare
  end

endmodule

/* hdl/fetchStage.sv */
module fetchStage import rvPkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  redirect,
  input  word_t redirectTarget,
  input  word_t fetchInstr,
  output word_t fetchAddr,
  output word_t ifPc,
  output word_t ifInstr
);

  word_t pc;
  word_t pcNext;

  // Taken branch in resolve wins over sequential fetch
  assign pcNext    = redirect ? redirectTarget : pc + 32'd4;
  assign fetchAddr = pc;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc <= resetPc;
    end else begin
      pc <= pcNext;
    end
  end

  // ====================
  // Fetch/decode register
  // ====================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      ifInstr <= nopInstr;
    end else if (redirect) begin
      ifInstr <= nopInstr;       // Wrong-path word becomes a bubble
    end else begin
      ifInstr <= fetchInstr;
    end
  end

  always_ff @(posedge clock) begin
    ifPc <= pc;
  end

endmodule

/* hdl/registerFile.sv */
module registerFile import rvPkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  regAddr_t readAddrA,
  input  regAddr_t readAddrB,
  output word_t    readDataA,
  output word_t    readDataB,
  input  logic     writeEnable,
  input  regAddr_t writeAddr,
  input  word_t    writeData
);

  word_t regs [2**regAddrWidth];
  logic  writeLive;

  assign writeLive = writeEnable && (writeAddr != '0);  // x0 is never written

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**regAddrWidth; i++) begin
        regs[i] <= '0;
      end
    end else if (writeLive) begin
      regs[writeAddr] <= writeData;
    end
  end

  // Same-cycle write passes straight to the read ports
  assign readDataA = (writeLive && writeAddr == readAddrA) ? writeData : regs[readAddrA];
  assign readDataB = (writeLive && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

/* hdl/resolveStage.sv */
module resolveStage import rvPkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  word_t       mePc,
  input  word_t       meAluResult,
  input  word_t       meImm,
  input  regAddr_t    meRd,
  input  branchKind_t meBranch,
  input  logic        meRegWrite,
  input  logic        meZero,
  input  logic        meLess,
  output logic        redirect,
  output word_t       redirectTarget,
  output logic        fwdValid,
  output regAddr_t    fwdRd,
  output word_t       fwdValue,
  output logic        wbEnable,
  output regAddr_t    wbReg,
  output word_t       wbData
);

  logic isJump;

  assign isJump = (meBranch == brJal) || (meBranch == brJalr);

  // Branch decision
  always_comb begin
    case (meBranch)
      brBeq:        redirect = meZero;
      brBne:        redirect = !meZero;
      brBlt:        redirect = meLess;
      brBge:        redirect = !meLess;
      brJal, brJalr: redirect = 1'b1;
      default:      redirect = 1'b0;
    endcase
  end

  assign redirectTarget = (meBranch == brJalr) ? {meAluResult[xlen-1:1], 1'b0}
                                               : mePc + meImm;

  // Link address for jumps, otherwise the ALU result
  assign fwdValue = isJump ? mePc + 32'd4 : meAluResult;
  assign fwdValid = meRegWrite;
  assign fwdRd    = meRd;

  // ====================
  // Writeback register
  // ====================
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wbEnable <= 1'b0;
      wbReg    <= '0;
    end else begin
      wbEnable <= meRegWrite;
      wbReg    <= meRd;
    end
  end

  always_ff @(posedge clock) begin
    wbData <= fwdValue;
  end

endmodule

/* hdl/rvPipeline.sv */
module rvPipeline import rvPkg::*; (
  input  logic     clock,
  input  logic     reset,
  output word_t    fetchAddr,
  input  word_t    fetchInstr,
  output logic     wbEnable,
  output regAddr_t wbReg,
  output word_t    wbData
);

  // Fetch to decode
  word_t       ifPc;
  word_t       ifInstr;
  // Register file read ports
  regAddr_t    rfAddrA;
  regAddr_t    rfAddrB;
  word_t       rfDataA;
  word_t       rfDataB;
  // Decode to execute
  word_t       exPc;
  word_t       exImm;
  word_t       exRs1Val;
  word_t       exRs2Val;
  regAddr_t    exRs1;
  regAddr_t    exRs2;
  regAddr_t    exRd;
  aluOp_t      exAluOp;
  branchKind_t exBranch;
  logic        exUsePc;
  logic        exUseImm;
  logic        exRegWrite;
  // Execute to resolve
  word_t       mePc;
  word_t       meAluResult;
  word_t       meImm;
  regAddr_t    meRd;
  branchKind_t meBranch;
  logic        meRegWrite;
  logic        meZero;
  logic        meLess;
  // Resolve feedback
  logic        redirect;     // Also the flush of the three younger stages
  word_t       redirectTarget;
  logic        fwdValid;
  regAddr_t    fwdRd;
  word_t       fwdValue;

  fetchStage fetch0 (
    .clock, .reset, .redirect, .redirectTarget, .fetchInstr,
    .fetchAddr, .ifPc, .ifInstr
  );

  registerFile regs0 (
    .clock, .reset,
    .readAddrA (rfAddrA), .readAddrB (rfAddrB),
    .readDataA (rfDataA), .readDataB (rfDataB),
    .writeEnable (wbEnable), .writeAddr (wbReg), .writeData (wbData)
  );

  decodeStage decode0 (
    .clock, .reset, .flush (redirect), .ifPc, .ifInstr,
    .rfAddrA, .rfAddrB, .rfDataA, .rfDataB,
    .exPc, .exImm, .exRs1Val, .exRs2Val, .exRs1, .exRs2, .exRd,
    .exAluOp, .exBranch, .exUsePc, .exUseImm, .exRegWrite
  );

  executeStage execute0 (
    .clock, .reset, .flush (redirect),
    .exPc, .exImm, .exRs1Val, .exRs2Val, .exRs1, .exRs2, .exRd,
    .exAluOp, .exBranch, .exUsePc, .exUseImm, .exRegWrite,
    .fwdValid, .fwdRd, .fwdValue, .wbEnable, .wbReg, .wbData,
    .mePc, .meAluResult, .meImm, .meRd, .meBranch, .meRegWrite, .meZero, .meLess
  );

  resolveStage resolve0 (
    .clock, .reset,
    .mePc, .meAluResult, .meImm, .meRd, .meBranch, .meRegWrite, .meZero, .meLess,
    .redirect, .redirectTarget, .fwdValid, .fwdRd, .fwdValue,
    .wbEnable, .wbReg, .wbData
  );

endmodule

/* hdl/rvPkg.sv */
package rvPkg;

  // ====================
  // Widths and base types
  // ====================
  localparam int xlen         = 32;
  localparam int regAddrWidth = 5;

  typedef logic [xlen-1:0]         word_t;     // Data, instructions and addresses
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // ====================
  // Control encodings
  // ====================
  typedef enum logic [3:0] {
    aluAdd  = 4'd0,
    aluSub  = 4'd1,
    aluSrl  = 4'd2,
    aluSll  = 4'd3,
    aluSlt  = 4'd4,
    aluSltu = 4'd5,
    aluMul  = 4'd6,
    aluNone = 4'd7   // Result forced to zero
  } aluOp_t;

  typedef enum logic [2:0] {
    brNone = 3'd0,
    brBeq  = 3'd1,
    brBne  = 3'd2,
    brBlt  = 3'd3,
    brBge  = 3'd4,
    brJal  = 3'd5,
    brJalr = 3'd6
  } branchKind_t;

  // Major opcodes, instr[6:0]
  localparam logic [6:0] opImm    = 7'b0010011;
  localparam logic [6:0] opReg    = 7'b0110011;
  localparam logic [6:0] opLui    = 7'b0110111;
  localparam logic [6:0] opAuipc  = 7'b0010111;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opJal    = 7'b1101111;
  localparam logic [6:0] opJalr   = 7'b1100111;

  // funct7 variants of the kept R-type and shift encodings
  localparam logic [6:0] f7Base = 7'b0000000;
  localparam logic [6:0] f7Alt  = 7'b0100000;  // SUB
  localparam logic [6:0] f7Mul  = 7'b0000001;  // M extension

  // ====================
  // Reset values
  // ====================
  localparam word_t nopInstr = 32'h0000_0013;  // ADDI x0, x0, 0
  localparam word_t resetPc  = '0;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module rvPipelineTb -f sim.f -o rvPipelineSim
./obj_dir/rvPipelineSim | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
echo "Simulation finished without failure"

/* sim.f */
hdl/rvPkg.sv
hdl/fetchStage.sv
hdl/registerFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/resolveStage.sv
hdl/rvPipeline.sv
verif/rvModelPkg.sv
verif/rvPipelineTb.sv

/* verif/rvModelPkg.sv */
package rvModelPkg;
  import rvPkg::*;

  // ====================
  // Test constants
  // ====================
  localparam int progLen      = 96;    // Words per random program
  localparam int memAddrWidth = 7;
  localparam int memDepth     = 1 << memAddrWidth;
  localparam int numPrograms  = 4;     // Program 0 is straight-line code
  localparam int unsigned seed = 66;

  int unsigned lcgState = seed;

  // Expected writebacks in program order
  regAddr_t expRegQ[$];
  word_t    expDataQ[$];

  function automatic int unsigned nextRand(int unsigned range);
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return (lcgState >> 8) % range;
  endfunction

  // Mostly x1..x7 so that nearby instructions depend on each other
  function automatic regAddr_t pickReg();
    int unsigned r;
    r = nextRand(10);
    if (r < 7) return regAddr_t'(1 + nextRand(7));
    if (r < 9) return '0;
    return regAddr_t'(nextRand(32));
  endfunction

  // ====================
  // Encoders
  // ====================
  function automatic word_t encI(logic [11:0] imm, regAddr_t rs1, logic [2:0] f3, regAddr_t rd,
                                 logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t encR(logic [6:0] f7, regAddr_t rs2, regAddr_t rs1, logic [2:0] f3,
                                 regAddr_t rd);
    return {f7, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic word_t encB(logic [12:0] off, regAddr_t rs2, regAddr_t rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
  endfunction

  function automatic word_t encJ(logic [20:0] off, regAddr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
  endfunction

  // One random instruction for word idx; all control flow goes forward
  function automatic word_t genInstr(int idx, bit withFlow);
    int unsigned sel;
    int          span;
    sel  = nextRand(withFlow ? 18 : 12);
    span = 1 + int'(nextRand(6));
    if (idx + span > progLen) begin
      span = progLen - idx;   // Target at most one word past the end
    end
    case (sel)
      0, 1:    return encI(12'(nextRand(4096)), pickReg(), 3'b000, pickReg(), opImm);
      2:       return encI(12'(nextRand(4096)), pickReg(), 3'b010, pickReg(), opImm);
      3:       return encI(12'(nextRand(4096)), pickReg(), 3'b011, pickReg(), opImm);
      4:       return encI({7'b0, 5'(nextRand(32))}, pickReg(), 3'b001, pickReg(), opImm);
      5:       return encI({7'b0, 5'(nextRand(32))}, pickReg(), 3'b101, pickReg(), opImm);
      6:       return encR(f7Base, pickReg(), pickReg(), 3'b000, pickReg());
      7:       return encR(f7Alt, pickReg(), pickReg(), 3'b000, pickReg());
      8:       return encR(f7Base, pickReg(), pickReg(), 3'b010, pickReg());
      9:       return encR(f7Base, pickReg(), pickReg(), 3'b011, pickReg());
      10:      return encR(f7Mul, pickReg(), pickReg(), 3'b000, pickReg());
      11:      return {20'(nextRand(1 << 20)), pickReg(), (nextRand(2) == 0) ? opLui : opAuipc};
      12:      return encB(13'(span * 4), pickReg(), pickReg(), 3'b000);
      13:      return encB(13'(span * 4), pickReg(), pickReg(), 3'b001);
      14:      return encB(13'(span * 4), pickReg(), pickReg(), 3'b100);
      15:      return encB(13'(span * 4), pickReg(), pickReg(), 3'b101);
      16:      return encJ(21'(span * 4), pickReg());
      default: return encI(12'((idx + span) * 4), '0, 3'b000, pickReg(), opJalr);  // JALR x0
    endcase
  endfunction

  // ====================
  // Instruction-set model
  // ====================
  function automatic void runModel(input word_t prog [memDepth]);
    word_t    regs [32];
    word_t    pc;
    word_t    instr;
    word_t    a;
    word_t    b;
    word_t    immI;
    word_t    res;
    word_t    next;
    regAddr_t rd;
    logic     hasRes;
    logic     taken;
    regs = '{default: '0};
    pc   = resetPc;
    while (pc < word_t'(progLen * 4)) begin
      instr  = prog[pc[memAddrWidth+1:2]];
      rd     = instr[11:7];
      a      = regs[instr[19:15]];
      b      = regs[instr[24:20]];
      immI   = {{20{instr[31]}}, instr[31:20]};
      next   = pc + 32'd4;
      hasRes = 1'b1;
      res    = '0;
      case (instr[6:0])
        opImm: begin
          case (instr[14:12])
            3'b000:  res = a + immI;
            3'b010:  res = word_t'($signed(a) < $signed(immI));
            3'b011:  res = word_t'(a < immI);
            3'b001:  res = a << instr[24:20];
            default: res = a >> instr[24:20];
          endcase
        end
        opReg: begin
          if (instr[25]) begin
            res = a * b;
          end else if (instr[30]) begin
            res = a - b;
          end else if (instr[14:12] == 3'b010) begin
            res = word_t'($signed(a) < $signed(b));
          end else if (instr[14:12] == 3'b011) begin
            res = word_t'(a < b);
          end else begin
            res = a + b;
          end
        end
        opLui:   res = {instr[31:12], 12'b0};
        opAuipc: res = pc + {instr[31:12], 12'b0};
        opJal: begin
          res  = pc + 32'd4;   // Link address
          next = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        end
        opJalr: begin
          res  = pc + 32'd4;
          next = (a + immI) & ~32'd1;
        end
        opBranch: begin
          hasRes = 1'b0;
          case (instr[14:12])
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            default: taken = ($signed(a) >= $signed(b));
          endcase
          if (taken) begin
            next = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
          end
        end
        default: hasRes = 1'b0;
      endcase
      if (hasRes && rd != '0) begin
        regs[rd] = res;
        expRegQ.push_back(rd);
        expDataQ.push_back(res);
      end
      pc = next;
    end
  endfunction

endpackage

/* verif/rvPipelineTb.sv */
module rvPipelineTb import rvPkg::*, rvModelPkg::*;;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockPeriod    = 4;
  localparam int resetCycles    = 10;
  localparam int idleCycles     = 20;
  localparam int watchdogCycles = numPrograms * progLen * 8 + 100;

  logic     clock;
  logic     reset;
  word_t    fetchAddr;
  word_t    fetchInstr;
  logic     wbEnable;
  regAddr_t wbReg;
  word_t    wbData;

  word_t imem [memDepth];

  int errorCount   = 0;
  int extraCount   = 0;
  int missingCount = 0;
  int checkedCount = 0;

  rvPipeline dut0 (
    .clock, .reset, .fetchAddr, .fetchInstr, .wbEnable, .wbReg, .wbData
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  // Instruction memory with a combinational read
  always_comb begin
    if (fetchAddr[1:0] == 2'b00 && fetchAddr < word_t'(progLen * 4)) begin
      fetchInstr = imem[fetchAddr[memAddrWidth+1:2]];
    end else begin
      fetchInstr = nopInstr;   // Outside the program
    end
  end

  task automatic checkValue(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // ====================
  // Writeback monitor
  // ====================
  always @(posedge clock) begin : monitor
    regAddr_t expectReg;
    word_t    expectData;
    if (!reset && wbEnable) begin
      if (expRegQ.size() == 0) begin
        extraCount++;
        $display("At %0d ns the DUT wrote back x%0d, but the program produces no more results",
                 $time, wbReg);
      end else begin
        expectReg  = expRegQ.pop_front();
        expectData = expDataQ.pop_front();
        checkValue(word_t'(wbReg), word_t'(expectReg), "writeback register");
        checkValue(wbData, expectData, "writeback data");
        checkedCount++;
      end
    end
  end

  // ====================
  // Program sequence
  // ====================
  initial begin : stimulus
    reset = 1'b1;
    for (int p = 0; p < numPrograms; p++) begin
      @(negedge clock);
      reset = 1'b1;
      for (int i = 0; i < memDepth; i++) begin
        imem[memAddrWidth'(i)] = (i < progLen) ? genInstr(i, p != 0) : nopInstr;
      end
      expRegQ.delete();
      expDataQ.delete();
      runModel(imem);
      repeat (resetCycles) @(negedge clock);
      // Core sits at the first fetch with writeback idle
      checkValue(fetchAddr, resetPc, "fetch address in reset");
      checkValue(word_t'(wbEnable), word_t'(1'b0), "writeback enable in reset");
      reset = 1'b0;
      // Wait for fetch to run past the last word
      while (fetchAddr < word_t'(progLen * 4)) begin
        @(negedge clock);
      end
      // Idle cycles drain the pipeline and any late redirect
      repeat (idleCycles) @(negedge clock);
      if (expRegQ.size() != 0) begin
        missingCount += expRegQ.size();
        $display("Program %0d ended with %0d expected writebacks that the DUT never made",
                 p, expRegQ.size());
        expRegQ.delete();
        expDataQ.delete();
      end
    end

    $display("Writebacks checked %0d, value errors %0d, extra %0d, missing %0d",
             checkedCount, errorCount, extraCount, missingCount);
    if (errorCount + extraCount + missingCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdogCycles * clockPeriod);
    $display("Timeout after %0d cycles, the pipeline appears to hang", watchdogCycles);
    $display("Result: FAILED");
    $finish;
  end

endmodule
